/* bench/core_glue_tb.sv */
// Testbench for the MSX glue logic
//   Clock, synchronous reset and file-driven vectors
//   LFSR-driven SPI activity test for the LEDs
//   Cycle limit derived from the vector count

`timescale 1ns/1ps

module core_glue_tb;

   import core_cfg_pkg::*;
   import mem_pkg::*;

   // Settle time, mount cycle and two bursts of eight steps
   localparam int act_cycles = 20 + 1 + 2 * (8 * 3 + 21);

   logic        clock_bus;
   logic        rst_n;
   logic        board_reset, upload_reset, img_mounted_sd, img_mounted_fdd, fdc_enable;
   logic        spi_clk, spi_mosi, sd_miso, vsd_miso, ioctl_download, motor;
   logic        cas_dout, tape_adc, tape_adc_act, dl_request, dl_rd, cas_rd;
   logic        forced_scandoubler;
   status_t     status;
   img_size_t   img_size;
   logic [5:0]  ioctl_index;
   ddr_addr_t   dl_addr, cas_addr, ddr3_addr;
   logic [11:0] hdmi_width, hdmi_height;
   logic        hard_reset, core_reset, sd_cs, sd_sck, sd_mosi, spi_miso, led_user;
   logic [1:0]  led_disk, vga_sl;
   logic        tape_in, cas_load, play, rewind, ddr3_rd, scandoubler, hq2x;
   ratio_t      arx, ary, crop_size;

   int          cycle_count;
   int          cycle_limit;
   logic [31:0] lfsr_state;

   core_glue_top #(.act_hold_cycles(16)) i_dut (.*);

   initial clock_bus = 1'b0;
   always #10 clock_bus = ~clock_bus;

   // ====================
   // Timeout
   // ====================

   always @(posedge clock_bus) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout, the run went past %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   end

   task automatic check_val(input string name, input logic [63:0] exp_v,
                            input logic [63:0] act_v);
      assert (exp_v === act_v) else begin
         $display("Fail %s expected %h actual %h", name, exp_v, act_v);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One clock edge, then back to the drive point
   task automatic next_cycle();
      @(posedge clock_bus);
      #2;
   endtask

   task automatic check_leds(input string name, input logic virt, input logic on);
      check_val(name, {61'd0, 1'b1, on & virt, on & ~virt},
                {61'd0, led_disk[1], led_user, led_disk[0]});
   endtask

   // Random MOSI edges, LED on 3 cycles after each, off 21 after the last
   task automatic act_burst(input string name, input logic virt);
      logic b;
      int   since;
      since = 100;
      repeat (8) begin
         lfsr_state = lfsr_step(lfsr_state);
         b = lfsr_state[0];
         if (b != spi_mosi) begin
            spi_mosi = b;
            repeat (2) next_cycle();
            @(posedge clock_bus);
            #1;
            check_leds(name, virt, 1'b1);
            #1;
            since = 3;
         end else begin
            next_cycle();
            since++;
         end
      end
      while (since < 21) begin
         next_cycle();
         since++;
      end
      check_leds(name, virt, 1'b0);
   endtask

   // ====================
   // Main sequence
   // ====================

   initial begin : main
      int           fd;
      int           n_vec;
      int           n_read;
      string        line;
      string        name;
      logic [17:0]  in_bits;
      logic [13:0]  exp_bits;
      logic [63:0]  exp_sl, exp_arx, exp_ary, exp_crop, exp_addr;

      {board_reset, upload_reset, img_mounted_sd, img_mounted_fdd, fdc_enable, spi_clk,
       spi_mosi, sd_miso, vsd_miso, ioctl_download, motor, cas_dout, tape_adc,
       tape_adc_act, dl_request, dl_rd, cas_rd, forced_scandoubler} = '0;
      status      = '0;
      img_size    = '0;
      ioctl_index = '0;
      dl_addr     = '0;
      cas_addr    = '0;
      hdmi_width  = '0;
      hdmi_height = '0;
      rst_n       = 1'b0;
      cycle_count = 0;
      cycle_limit = 1000;
      lfsr_state  = 32'h39df_4633;

      // First pass counts the vectors for the cycle limit
      n_vec = 0;
      fd = $fopen("bench/glue_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file");
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 2 && line[0] != "#") n_vec++;
      end
      $fclose(fd);
      cycle_limit = 2 * (8 + n_vec + act_cycles) + 200;

      // Both resets held high during rst_n
      repeat (8) @(posedge clock_bus);
      #1;
      check_val("reset_hold", 64'd3, 64'({hard_reset, core_reset}));
      #1;
      rst_n = 1'b1;

      fd = $fopen("bench/glue_stimulus.txt", "r");
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 2 && line[0] != "#") begin
            n_read = $sscanf(line, "%s %h %b %h %h %h %h %h %h %b %h %h %h %h %h",
                             name, status, in_bits, img_size, ioctl_index, dl_addr,
                             cas_addr, hdmi_width, hdmi_height, exp_bits, exp_sl,
                             exp_arx, exp_ary, exp_crop, exp_addr);
            if (n_read != 15) begin
               $display("Malformed stimulus line: %s", line);
               $display("TESTBENCH FAILED");
               $fatal(1);
            end
            {board_reset, upload_reset, img_mounted_sd, img_mounted_fdd, fdc_enable,
             spi_clk, spi_mosi, sd_miso, vsd_miso, ioctl_download, motor, cas_dout,
             tape_adc, tape_adc_act, dl_request, dl_rd, cas_rd, forced_scandoubler} = in_bits;
            @(posedge clock_bus);
            #1;
            check_val({name, " flags"}, 64'(exp_bits),
                      64'({hard_reset, core_reset, sd_cs, sd_sck, sd_mosi, spi_miso,
                           led_disk[1], tape_in, cas_load, play, rewind, ddr3_rd,
                           hq2x, scandoubler}));
            check_val({name, " vga_sl"}, exp_sl, 64'(vga_sl));
            check_val({name, " arx"}, exp_arx, 64'(arx));
            check_val({name, " ary"}, exp_ary, 64'(ary));
            check_val({name, " crop_size"}, exp_crop, 64'(crop_size));
            check_val({name, " ddr3_addr"}, exp_addr, 64'(ddr3_addr));
            #1;
         end
      end
      $fclose(fd);

      // Activity on the physical card, then on the image
      {spi_clk, spi_mosi, sd_miso, vsd_miso, img_mounted_sd} = '0;
      status = '0;
      repeat (20) next_cycle();
      act_burst("act_phys", 1'b0);
      img_mounted_sd = 1'b1;
      img_size       = 64'd1;
      next_cycle();
      img_mounted_sd = 1'b0;
      act_burst("act_virt", 1'b1);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* bench/glue_stimulus.txt */
# name status in_bits img_size ioctl_index dl_addr cas_addr hdmi_w hdmi_h
# exp_flags exp_vga_sl exp_arx exp_ary exp_crop exp_ddr3_addr (hex, flags in binary)
rst_idle 0 000000000000000000 0 0 0 0 0 0 00000010000000 0 4 3 0 0
rst_board 0 100000000000000000 0 0 0 0 0 0 11000010001000 0 4 3 0 0
rst_menu 1 000000000000000000 0 0 0 0 0 0 11000010001000 0 4 3 0 0
rst_upload 0 010000000000000000 0 0 0 0 0 0 11000010001000 0 4 3 0 0
rst_detach 400 000000000000000000 0 0 0 0 0 0 01000010001000 0 4 3 0 0
rst_close 200000 000000000000000000 0 0 0 0 0 0 01000010001000 0 4 3 0 0
mount_nofdc 1000 000100000000000000 0 0 0 0 0 0 00000010000000 0 4 3 0 0
mount_fdc 1000 000110000000000000 0 0 0 0 0 0 01000010001000 0 4 3 0 0
sd_phys 0 000001110000000000 0 0 0 0 0 0 00011110000000 0 4 3 0 0
sd_mount 0 001001101000000000 1000 0 0 0 0 0 00100110000000 0 4 3 0 0
sd_virt_miso 0 000001110000000000 0 0 0 0 0 0 00100010000000 0 4 3 0 0
sd_unmount 0 001000010000000000 0 0 0 0 0 0 00000110000000 0 4 3 0 0
cas_other 0 000000000100000000 0 3 0 0 0 0 00000010000000 0 4 3 0 0
cas_dl 0 000000000100000000 0 5 0 0 0 0 00000010001000 0 4 3 0 0
cas_end 0 000000000010000000 0 5 0 0 0 0 00000010100000 0 4 3 0 0
cas_play 0 000000000001000000 0 0 0 0 0 0 00000011110000 0 4 3 0 0
cas_rewind 200 000000000000000000 0 0 0 0 0 0 00000010111000 0 4 3 0 0
tape_adc 10000000000 000000000001110000 0 0 0 0 0 0 00000011110000 0 4 3 0 0
tape_adc_off 10000000000 000000000001100000 0 0 0 0 0 0 00000010110000 0 4 3 0 0
ddr_dl 0 000000000000001100 0 0 1234567 abcdef0 0 0 00000010110100 0 4 3 0 1234567
ddr_cas 0 000000000000000010 0 0 1234567 abcdef0 0 0 00000010110100 0 4 3 0 abcdef0
ddr_dl_idle 0 000000000000001010 0 0 1234567 abcdef0 0 0 00000010110000 0 4 3 0 1234567
vid_s1_a0 8 000000000000000000 0 0 0 0 0 0 00000010110011 0 4 3 0 0
vid_s2_a1 12 000000000000000000 0 0 0 0 0 0 00000010110001 1 0 0 0 0
vid_s3_a0 18 000000000000000000 0 0 0 0 0 0 00000010110001 2 4 3 0 0
vid_s4_a2 24 000000000000000000 0 0 0 0 0 0 00000010110001 3 1 0 0 0
vid_s5_a3 2e 000000000000000000 0 0 0 0 0 0 00000010110001 0 2 0 0 0
vid_s6_a0 30 000000000000000000 0 0 0 0 0 0 00000010110001 1 4 3 0 0
vid_s7_a0 38 000000000000000000 0 0 0 0 0 0 00000010110001 2 4 3 0 0
crop_1080 0 000000000000000000 0 0 0 0 780 438 00000010110000 0 4 3 d8 0
crop_forced 0 000000000000000001 0 0 0 0 780 438 00000010110001 0 4 3 0 0
crop_scale 8 000000000000000000 0 0 0 0 780 438 00000010110011 0 4 3 0 0
crop_720 0 000000000000000000 0 0 0 0 500 2d0 00000010110000 0 4 3 0 0
crop_back 0 000000000000000000 0 0 0 0 780 438 00000010110000 0 4 3 d8 0

/* compile.f */
design/core_cfg_pkg.sv
design/mem_pkg.sv
design/reset_ctrl.sv
design/sd_select.sv
design/tape_ctrl.sv
design/video_cfg.sv
design/core_glue_top.sv
bench/core_glue_tb.sv

/* design/core_cfg_pkg.sv */
// Menu and video configuration definitions
//   Status word type and bit positions of the menu fields
//   Aspect, scale and ratio types
//   Default aspect ratio and 1080p crop constants
//   Download index of a cassette file

package core_cfg_pkg;

   // ====================
   // Types
   // ====================

   // Menu status word from the host
   typedef logic [63:0] status_t;

   // Aspect menu field, 0 means original ratio
   typedef logic [1:0] aspect_t;

   // Scandoubler effect field
   typedef logic [2:0] scale_t;

   // Aspect ratio or crop height for the scaler
   typedef logic [11:0] ratio_t;

   // ====================
   // Status bit positions
   // ====================

   localparam int st_reset       = 0;
   localparam int st_aspect_lo   = 1;
   localparam int st_scale_lo    = 3;
   localparam int st_rewind      = 9;
   localparam int st_detach      = 10;
   localparam int st_reset_mount = 12;
   localparam int st_reset_close = 21;
   localparam int st_cas_src     = 40;

   // Original 4:3 aspect
   localparam ratio_t arx_default = 12'd4;
   localparam ratio_t ary_default = 12'd3;

   // Crop height and output size for 1080p
   localparam ratio_t      crop_216     = 12'd216;
   localparam logic [11:0] hdmi_w_1080p = 12'd1920;
   localparam logic [11:0] hdmi_h_1080p = 12'd1080;

   // Cassette file slot in the download menu
   localparam logic [5:0] cas_file_index = 6'd5;

endpackage

/* design/core_glue_top.sv */
// Glue logic around the MSX core
//   Reset generation, SD card routing, cassette control
//   DDR3 read port sharing and video settings decode

`timescale 1ns/1ps

module core_glue_top #(
   parameter int unsigned act_hold_cycles = mem_pkg::act_hold_default
) (
   input  logic                  clock_bus,
   input  logic                  rst_n,
   input  logic                  board_reset,
   input  core_cfg_pkg::status_t status,
   input  logic                  upload_reset,
   input  logic                  img_mounted_sd,
   input  logic                  img_mounted_fdd,
   input  mem_pkg::img_size_t    img_size,
   input  logic                  fdc_enable,
   input  logic                  spi_clk,
   input  logic                  spi_mosi,
   input  logic                  sd_miso,
   input  logic                  vsd_miso,
   input  logic                  ioctl_download,
   input  logic [5:0]            ioctl_index,
   input  logic                  motor,
   input  logic                  cas_dout,
   input  logic                  tape_adc,
   input  logic                  tape_adc_act,
   input  logic                  dl_request,
   input  mem_pkg::ddr_addr_t    dl_addr,
   input  logic                  dl_rd,
   input  mem_pkg::ddr_addr_t    cas_addr,
   input  logic                  cas_rd,
   input  logic                  forced_scandoubler,
   input  logic [11:0]           hdmi_width,
   input  logic [11:0]           hdmi_height,
   output logic                  hard_reset,
   output logic                  core_reset,
   output logic                  sd_cs,
   output logic                  sd_sck,
   output logic                  sd_mosi,
   output logic                  spi_miso,
   output logic                  led_user,
   output logic [1:0]            led_disk,
   output logic                  tape_in,
   output logic                  cas_load,
   output logic                  play,
   output logic                  rewind,
   output mem_pkg::ddr_addr_t    ddr3_addr,
   output logic                  ddr3_rd,
   output logic [1:0]            vga_sl,
   output logic                  scandoubler,
   output logic                  hq2x,
   output core_cfg_pkg::ratio_t  arx,
   output core_cfg_pkg::ratio_t  ary,
   output core_cfg_pkg::ratio_t  crop_size
);

   reset_ctrl i_reset_ctrl (
      .clock_bus       (clock_bus),
      .rst_n           (rst_n),
      .board_reset     (board_reset),
      .status          (status),
      .upload_reset    (upload_reset),
      .img_mounted_fdd (img_mounted_fdd),
      .fdc_enable      (fdc_enable),
      .hard_reset      (hard_reset),
      .core_reset      (core_reset)
   );

   sd_select #(
      .act_hold_cycles (act_hold_cycles)
   ) i_sd_select (
      .clock_bus       (clock_bus),
      .rst_n           (rst_n),
      .img_mounted_sd  (img_mounted_sd),
      .img_size        (img_size),
      .spi_clk         (spi_clk),
      .spi_mosi        (spi_mosi),
      .sd_miso         (sd_miso),
      .vsd_miso        (vsd_miso),
      .sd_cs           (sd_cs),
      .sd_sck          (sd_sck),
      .sd_mosi         (sd_mosi),
      .spi_miso        (spi_miso),
      .led_user        (led_user),
      .led_disk        (led_disk)
   );

   // Core reset also rewinds the tape
   tape_ctrl i_tape_ctrl (
      .clock_bus       (clock_bus),
      .rst_n           (rst_n),
      .core_reset      (core_reset),
      .status          (status),
      .ioctl_download  (ioctl_download),
      .ioctl_index     (ioctl_index),
      .motor           (motor),
      .cas_dout        (cas_dout),
      .tape_adc        (tape_adc),
      .tape_adc_act    (tape_adc_act),
      .dl_request      (dl_request),
      .dl_addr         (dl_addr),
      .dl_rd           (dl_rd),
      .cas_addr        (cas_addr),
      .cas_rd          (cas_rd),
      .tape_in         (tape_in),
      .cas_load        (cas_load),
      .play            (play),
      .rewind          (rewind),
      .ddr3_addr       (ddr3_addr),
      .ddr3_rd         (ddr3_rd)
   );

   video_cfg i_video_cfg (
      .clock_bus          (clock_bus),
      .rst_n              (rst_n),
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .vga_sl             (vga_sl),
      .scandoubler        (scandoubler),
      .hq2x               (hq2x),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size)
   );

endmodule

/* design/mem_pkg.sv */
// Memory side definitions
//   DDR3 byte address and image size types
//   SD activity counter type and default hold time

package mem_pkg;

   // ====================
   // Types
   // ====================

   // Byte address on the DDR3 read port
   typedef logic [27:0] ddr_addr_t;

   // Size of a mounted image in bytes
   typedef logic [63:0] img_size_t;

   // Cycles since the last SPI data edge
   typedef logic [31:0] act_count_t;

   // Roughly 50 ms at the system clock
   localparam int unsigned act_hold_default = 1000000;

endpackage

/* design/reset_ctrl.sv */
// Reset generation
//   Hard reset from board, menu and upload engine
//   Core reset adds detach, reset-close and reset after disk mount

`timescale 1ns/1ps

module reset_ctrl (
   input  logic                  clock_bus,
   input  logic                  rst_n,
   input  logic                  board_reset,
   input  core_cfg_pkg::status_t status,
   input  logic                  upload_reset,
   input  logic                  img_mounted_fdd,
   input  logic                  fdc_enable,
   output logic                  hard_reset,
   output logic                  core_reset
);

   import core_cfg_pkg::*;

   logic hard_req;
   logic mount_req;
   logic core_req;

   // Sources that also clear the loaded configuration
   assign hard_req = board_reset | status[st_reset] | upload_reset;

   // Disk mount reset needs the floppy controller present
   assign mount_req = status[st_reset_mount] & img_mounted_fdd & fdc_enable;

   assign core_req = hard_req
                   | status[st_detach]
                   | status[st_reset_close]
                   | mount_req;

   // Both levels held high while rst_n is low
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         hard_reset <= 1'b1;
         core_reset <= 1'b1;
      end else begin
         hard_reset <= hard_req;
         core_reset <= core_req;
      end
   end

endmodule

/* design/sd_select.sv */
// SD card selection
//   Virtual card select latched on image mount
//   SPI routing to the physical or virtual card
//   Activity counter for the user and disk LEDs

`timescale 1ns/1ps

module sd_select #(
   parameter int unsigned act_hold_cycles = mem_pkg::act_hold_default
) (
   input  logic                clock_bus,
   input  logic                rst_n,
   input  logic                img_mounted_sd,
   input  mem_pkg::img_size_t  img_size,
   input  logic                spi_clk,
   input  logic                spi_mosi,
   input  logic                sd_miso,
   input  logic                vsd_miso,
   output logic                sd_cs,
   output logic                sd_sck,
   output logic                sd_mosi,
   output logic                spi_miso,
   output logic                led_user,
   output logic [1:0]          led_disk
);

   import mem_pkg::*;

   localparam act_count_t hold_count = act_count_t'(act_hold_cycles);

   logic       vsd_sel;
   logic       sel_miso;
   logic       old_mosi;
   logic       old_miso;
   logic       sd_act;
   act_count_t act_count;

   // ====================
   // Card select
   // ====================

   // Zero size on mount means the image was removed
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_sd) begin
         vsd_sel <= |img_size;
      end
   end

   assign sel_miso = vsd_sel ? vsd_miso : sd_miso;
   assign spi_miso = sel_miso;

   // Physical card idle while the image is in use
   assign sd_cs   = vsd_sel;
   assign sd_sck  = spi_clk & ~vsd_sel;
   assign sd_mosi = spi_mosi & ~vsd_sel;

   // ====================
   // Activity
   // ====================

   // Previous data line levels for edge detection
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
      end else begin
         old_mosi <= spi_mosi;
         old_miso <= sel_miso;
      end
   end

   // Count up to the hold value, restart on any data edge
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         act_count <= hold_count;
         sd_act    <= 1'b0;
      end else begin
         sd_act <= 1'b0;
         if (act_count < hold_count) begin
            act_count <= act_count + act_count_t'(1);
            sd_act    <= 1'b1;
         end
         if ((old_mosi ^ spi_mosi) | (old_miso ^ sel_miso)) begin
            act_count <= '0;
         end
      end
   end

   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

/* design/tape_ctrl.sv */
// Cassette control
//   Cassette loaded latch on end of a CAS download
//   Play, rewind and tape input selection
//   DDR3 read port shared between download engine and tape player

`timescale 1ns/1ps

module tape_ctrl (
   input  logic                  clock_bus,
   input  logic                  rst_n,
   input  logic                  core_reset,
   input  core_cfg_pkg::status_t status,
   input  logic                  ioctl_download,
   input  logic [5:0]            ioctl_index,
   input  logic                  motor,
   input  logic                  cas_dout,
   input  logic                  tape_adc,
   input  logic                  tape_adc_act,
   input  logic                  dl_request,
   input  mem_pkg::ddr_addr_t    dl_addr,
   input  logic                  dl_rd,
   input  mem_pkg::ddr_addr_t    cas_addr,
   input  logic                  cas_rd,
   output logic                  tape_in,
   output logic                  cas_load,
   output logic                  play,
   output logic                  rewind,
   output mem_pkg::ddr_addr_t    ddr3_addr,
   output logic                  ddr3_rd
);

   import core_cfg_pkg::*;

   logic cas_active;
   logic cas_active_q;

   // ====================
   // Cassette load
   // ====================

   assign cas_active = ioctl_download & (ioctl_index == cas_file_index);

   // Falling edge of the CAS download marks a tape in place
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         cas_active_q <= 1'b0;
         cas_load     <= 1'b0;
      end else begin
         cas_active_q <= cas_active;
         if (cas_active_q & ~cas_active) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Motor relay is active low
   assign play   = ~motor & cas_load;
   assign rewind = status[st_rewind] | cas_active | core_reset;

   // File player or ADC comparator
   assign tape_in = status[st_cas_src] ? (tape_adc & tape_adc_act) : cas_dout;

   // ====================
   // DDR3 read port
   // ====================

   assign ddr3_addr = dl_request ? dl_addr : cas_addr;
   assign ddr3_rd   = dl_request ? dl_rd : cas_rd;

endmodule

/* design/video_cfg.sv */
// Video settings decode
//   Scanline level, scandoubler and hq2x from the effect field
//   Aspect ratio from the aspect field
//   216-line crop for 1080p output

`timescale 1ns/1ps

module video_cfg (
   input  logic                  clock_bus,
   input  logic                  rst_n,
   input  core_cfg_pkg::status_t status,
   input  logic                  forced_scandoubler,
   input  logic [11:0]           hdmi_width,
   input  logic [11:0]           hdmi_height,
   output logic [1:0]            vga_sl,
   output logic                  scandoubler,
   output logic                  hq2x,
   output core_cfg_pkg::ratio_t  arx,
   output core_cfg_pkg::ratio_t  ary,
   output core_cfg_pkg::ratio_t  crop_size
);

   import core_cfg_pkg::*;

   aspect_t ar;
   scale_t  scale;
   scale_t  sl;
   logic    is_1080p;

   assign ar    = status[st_aspect_lo +: $bits(aspect_t)];
   assign scale = status[st_scale_lo +: $bits(scale_t)];

   // ====================
   // Scaler controls
   // ====================

   // Effect 0 is none, 1 is hq2x, 2 and up are CRT levels
   assign sl          = (scale != '0) ? scale - scale_t'(1) : '0;
   assign vga_sl      = sl[1:0];
   assign hq2x        = (scale == scale_t'(1));
   assign scandoubler = forced_scandoubler | (scale != '0);

   // Non-zero aspect selects a custom ratio slot
   assign arx = (ar == '0) ? arx_default : ratio_t'(ar - aspect_t'(1));
   assign ary = (ar == '0) ? ary_default : '0;

   // ====================
   // 1080p crop
   // ====================

   assign is_1080p = (hdmi_width == hdmi_w_1080p) && (hdmi_height == hdmi_h_1080p);

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         crop_size <= '0;
      end else if (is_1080p && !scandoubler) begin
         crop_size <= crop_216;
      end else begin
         crop_size <= '0;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/bash
# Build with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module core_glue_tb -o sim_glue > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_glue > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0
